/* bench/lsu_stimulus.txt */
# op addr(hex) store_data(hex) rd(hex) kind [expected rd data(hex), wb only]
# kinds: none wb misaligned buserror; "burst 1" drops the idle cycles, "burst 0" restores them
sw 00000010 deadbeef 00 none
lw 00000010 00000000 05 wb deadbeef
sb 00000021 000000a5 00 none
sh 00000022 0000817f 00 none
lw 00000020 00000000 06 wb 817fa500
lb 00000021 00000000 07 wb ffffffa5
lbu 00000021 00000000 08 wb 000000a5
lh 00000022 00000000 09 wb ffff817f
lhu 00000022 00000000 0a wb 0000817f
lb 00000020 00000000 0b wb 00000000
lb 00000023 00000000 0c wb ffffff81
lb 00000022 00000000 0d wb 0000007f
lh 00000020 00000000 0e wb ffffa500
sb 00000013 00000012 00 none
lh 00000010 00000000 0f wb ffffbeef
lhu 00000012 00000000 10 wb 000012ad
sw 00000032 11223344 00 misaligned
lw 00000011 00000000 11 misaligned
sh 00000013 0000ffff 00 misaligned
lhu 00000023 00000000 12 misaligned
lw 00000010 00000000 13 wb 12adbeef
lw 00000030 00000000 14 wb 00000000
lw 00000400 00000000 15 buserror
lbu 00000ffc 00000000 16 buserror
sw 00000800 00000055 00 buserror
lw 000003fc 00000000 17 wb 00000000
burst 1
sw 00000040 00000001 00 none
sw 00000044 80000002 00 none
sh 0000004a 0000f00d 00 none
lw 00000040 00000000 18 wb 00000001
lw 00000044 00000000 19 wb 80000002
lhu 0000004a 00000000 1a wb 0000f00d
lh 0000004a 00000000 1b wb fffff00d
lw 00000048 00000000 1c wb f00d0000
lw 00000404 00000000 1d buserror
lb 00000047 00000000 1e wb ffffff80
burst 0

/* verilog.f */
common/lsu_pkg.sv
common/mem_bus_pkg.sv
lsu/lsu_align.sv
lsu/lsu_core.sv
src/data_ram.sv
src/lsu_subsys_top.sv
bench/lsu_tb.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing
TOP      = lsu_tb
FILELIST = verilog.f
OBJ_DIR  = obj_dir
LOG      = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Regression passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* bench/lsu_tb.sv */
//////////////////////////////////////////////////
// LSU subsystem testbench
// Replays the command file into the LSU, RAM and
// alignment block and checks every result pulse
// against the expected values in the file
//////////////////////////////////////////////////

`timescale 1ns/1ps

module lsu_tb;
  import lsu_pkg::*;

  typedef logic [95:0] word_t;  // Up to 12 characters of a token

  localparam int         READY_TIMEOUT = 50;   // Cycles a command may wait for ready
  localparam int         DRAIN_TIMEOUT = 200;  // Cycles for the last results
  localparam logic [1:0] KIND_NONE     = 2'd0;
  localparam logic [1:0] KIND_WB       = 2'd1;
  localparam logic [1:0] KIND_MIS      = 2'd2;
  localparam logic [1:0] KIND_BUSERR   = 2'd3;

  // One expected result
  typedef struct packed {
    logic [1:0]  kind;
    logic        store;  // Misaligned store rather than load
    logic [4:0]  dest;
    logic [31:0] value;  // Write-back data or exception address
  } expect_t;

  logic                      clk_i;
  logic                      rstn_i;
  logic                      lsu_valid_i;
  lsu_cmd_t                  lsu_cmd_i;
  logic                      lsu_ready_o;
  logic [DATA_WIDTH-1:0]     rf_data_o;
  logic                      rf_wb_o;
  logic [REG_ADDR_WIDTH-1:0] rf_dest_o;
  logic                      ctrl_misaligned_load_o;
  logic                      ctrl_misaligned_store_o;
  logic                      ctrl_bus_error_o;
  logic [DATA_WIDTH-1:0]     ctrl_exception_addr_o;

  expect_t bus_q[$];    // Write-backs and bus errors, bus order
  expect_t mis_q[$];    // Misaligned flags, command order
  logic    in_burst;    // No idle cycles between commands
  logic    stall_seen;  // Skid buffer went full

  lsu_subsys_top DUT (
    .clk_i                   (clk_i),
    .rstn_i                  (rstn_i),
    .lsu_valid_i             (lsu_valid_i),
    .lsu_cmd_i               (lsu_cmd_i),
    .lsu_ready_o             (lsu_ready_o),
    .rf_data_o               (rf_data_o),
    .rf_wb_o                 (rf_wb_o),
    .rf_dest_o               (rf_dest_o),
    .ctrl_misaligned_load_o  (ctrl_misaligned_load_o),
    .ctrl_misaligned_store_o (ctrl_misaligned_store_o),
    .ctrl_bus_error_o        (ctrl_bus_error_o),
    .ctrl_exception_addr_o   (ctrl_exception_addr_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;  // 8 ns period
  end

  //////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////
  task automatic stop_with_failure();
    $display("Regression failed");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
      stop_with_failure();
    end
  endtask

  // Mnemonic to opcode
  task automatic parse_opcode(input word_t name, output lsu_ctrl_e op,
                              output logic store, output logic ok);
    ok    = 1'b1;
    store = 1'b0;
    op    = LSU_LOAD_WORD;
    case (name)
      word_t'("lb"):  op = LSU_LOAD_BYTE;
      word_t'("lh"):  op = LSU_LOAD_HALF_WORD;
      word_t'("lw"):  op = LSU_LOAD_WORD;
      word_t'("lbu"): op = LSU_LOAD_BYTE_U;
      word_t'("lhu"): op = LSU_LOAD_HALF_WORD_U;
      word_t'("sb"): begin
        op    = LSU_STORE_BYTE;
        store = 1'b1;
      end
      word_t'("sh"): begin
        op    = LSU_STORE_HALF_WORD;
        store = 1'b1;
      end
      word_t'("sw"): begin
        op    = LSU_STORE_WORD;
        store = 1'b1;
      end
      default:        ok = 1'b0;
    endcase
  endtask

  // Hold valid until the command is taken, then queue its result
  task automatic send_command(input lsu_cmd_t cmd, input expect_t exp);
    int waited;
    waited      = 0;
    lsu_cmd_i   = cmd;
    lsu_valid_i = 1'b1;
    @(negedge clk_i);
    while (!lsu_ready_o) begin
      if (waited >= READY_TIMEOUT) begin
        $display("Command to address %h was never accepted, ready stayed low", cmd.addr);
        stop_with_failure();
      end else begin
        waited++;
        @(negedge clk_i);
      end
    end
    @(posedge clk_i);  // Fires on this edge
    #1;
    lsu_valid_i = 1'b0;
    if (exp.kind == KIND_MIS) mis_q.push_back(exp);
    else if (exp.kind != KIND_NONE) bus_q.push_back(exp);
  endtask

  //////////////////////////////////////////////////
  // Monitor
  //////////////////////////////////////////////////
  always @(negedge clk_i) begin
    expect_t exp;
    if (!rstn_i) begin
      // Everything quiet in reset
      check_value("lsu_ready_o in reset", 32'(lsu_ready_o), 32'd0);
      check_value("rf_wb_o in reset", 32'(rf_wb_o), 32'd0);
      check_value("ctrl_bus_error_o in reset", 32'(ctrl_bus_error_o), 32'd0);
      check_value("ctrl_misaligned_load_o in reset", 32'(ctrl_misaligned_load_o), 32'd0);
      check_value("ctrl_misaligned_store_o in reset", 32'(ctrl_misaligned_store_o), 32'd0);
    end else begin
      if (in_burst && lsu_valid_i && !lsu_ready_o) stall_seen = 1'b1;
      if (rf_wb_o || ctrl_bus_error_o) begin
        if (bus_q.size() == 0) begin
          $display("Result pulse at %0t while no load or bus error was pending", $time);
          stop_with_failure();
        end else begin
          exp = bus_q.pop_front();
          check_value("result kind", 32'(rf_wb_o ? KIND_WB : KIND_BUSERR), 32'(exp.kind));
          if (rf_wb_o) begin
            check_value("rf_dest_o", 32'(rf_dest_o), 32'(exp.dest));
            check_value("rf_data_o", rf_data_o, exp.value);
          end else begin
            check_value("bus error address", ctrl_exception_addr_o, exp.value);
          end
        end
      end
      if (ctrl_misaligned_load_o || ctrl_misaligned_store_o) begin
        if (mis_q.size() == 0) begin
          $display("Misaligned flag at %0t without a misaligned command", $time);
          stop_with_failure();
        end else begin
          exp = mis_q.pop_front();
          check_value("misaligned store flag", 32'(ctrl_misaligned_store_o), 32'(exp.store));
          check_value("misaligned load flag", 32'(ctrl_misaligned_load_o), 32'(!exp.store));
          check_value("misaligned address", ctrl_exception_addr_o, exp.value);
        end
      end else if (mis_q.size() != 0) begin
        // Flag belongs in the cycle right after the command fired
        $display("No misaligned flag at %0t one cycle after a misaligned command", $time);
        stop_with_failure();
      end
    end
  end

  //////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////
  initial begin
    int            fd;
    int            n;
    int            gap;
    int            waited;
    word_t         tok;
    word_t         kind_tok;
    logic [2047:0] rest;
    logic [31:0]   addr, data, rd, value;
    lsu_cmd_t      cmd;
    expect_t       exp;
    lsu_ctrl_e     op;
    logic          store, ok, done;

    rstn_i      = 1'b0;
    lsu_valid_i = 1'b0;
    lsu_cmd_i   = '0;
    in_burst    = 1'b0;
    stall_seen  = 1'b0;
    void'($urandom(32'h5b3ab522));

    fd = $fopen("bench/lsu_stimulus.txt", "r");
    if (fd == 0) begin
      $display("Cannot open bench/lsu_stimulus.txt");
      stop_with_failure();
    end

    repeat (16) @(posedge clk_i);
    #1 rstn_i = 1'b1;

    done = 1'b0;
    while (!done) begin
      n = $fscanf(fd, "%s", tok);
      if (n != 1) begin
        done = 1'b1;  // End of file
      end else if (tok == word_t'("#")) begin
        n = $fgets(rest, fd);
      end else if (tok == word_t'("burst")) begin
        n        = $fscanf(fd, "%d", value);
        in_burst = (value != 0);
      end else begin
        n = $fscanf(fd, "%h %h %h %s", addr, data, rd, kind_tok);
        parse_opcode(tok, op, store, ok);
        if (n != 4 || !ok) begin
          $display("Stimulus line with opcode %0s cannot be read", tok);
          stop_with_failure();
        end
        exp       = '0;
        exp.store = store;
        exp.dest  = rd[4:0];
        exp.value = addr;  // Exception kinds report the address
        if (kind_tok == word_t'("wb")) begin
          n         = $fscanf(fd, "%h", value);
          exp.kind  = KIND_WB;
          exp.value = value;
        end else if (kind_tok == word_t'("misaligned")) begin
          exp.kind = KIND_MIS;
        end else if (kind_tok == word_t'("buserror")) begin
          exp.kind = KIND_BUSERR;
        end else if (kind_tok == word_t'("none")) begin
          exp.kind = KIND_NONE;
        end else begin
          $display("Unknown result kind %0s in stimulus file", kind_tok);
          stop_with_failure();
        end
        cmd.cmd     = op;
        cmd.addr    = addr;
        cmd.data    = data;
        cmd.regdest = rd[4:0];
        send_command(cmd, exp);
        if (!in_burst) begin
          gap = $urandom_range(2, 0);  // Zero means back to back
          repeat (gap) begin
            @(posedge clk_i);
            #1;
          end
        end
      end
    end
    $fclose(fd);

    // Drain outstanding results
    waited = 0;
    while (bus_q.size() != 0 || mis_q.size() != 0) begin
      if (waited >= DRAIN_TIMEOUT) begin
        $display("Timeout with %0d bus and %0d misaligned results missing",
                 bus_q.size(), mis_q.size());
        stop_with_failure();
      end else begin
        waited++;
        @(negedge clk_i);
      end
    end
    repeat (10) @(posedge clk_i);  // Room for stray pulses
    check_value("skid buffer full at least once", 32'(stall_seen), 32'd1);

    $display("Regression passed");
    $finish;
  end

endmodule

/* src/lsu_subsys_top.sv */
//////////////////////////////////////////////////
// LSU subsystem top
// Alignment block, LSU core and data RAM
//////////////////////////////////////////////////

`timescale 1ns/1ps

module lsu_subsys_top (
  input  logic                               clk_i,
  input  logic                               rstn_i,
  // Command port
  input  logic                               lsu_valid_i,
  input  lsu_pkg::lsu_cmd_t                  lsu_cmd_i,
  output logic                               lsu_ready_o,
  // Register file
  output logic [lsu_pkg::DATA_WIDTH-1:0]     rf_data_o,
  output logic                               rf_wb_o,
  output logic [lsu_pkg::REG_ADDR_WIDTH-1:0] rf_dest_o,
  // Core controller
  output logic                               ctrl_misaligned_load_o,
  output logic                               ctrl_misaligned_store_o,
  output logic                               ctrl_bus_error_o,
  output logic [lsu_pkg::DATA_WIDTH-1:0]     ctrl_exception_addr_o
);
  import lsu_pkg::*;
  import mem_bus_pkg::*;

  // Aligned command path
  lsu_cmd_t              align_cmd;
  logic [3:0]            align_strobe;
  logic                  mis_load, mis_store;
  // Write-back path
  logic [DATA_WIDTH-1:0] rsp_word;
  lsu_ctrl_e             rsp_cmd;
  logic [1:0]            rsp_offset;
  // Memory bus
  data_req_t             bus_req;
  data_rsp_t             bus_rsp;
  logic                  bus_req_valid, bus_req_ready;
  logic                  bus_rsp_valid, bus_rsp_ready;

  lsu_align u_align (
    .cmd_i              (lsu_cmd_i),
    .cmd_o              (align_cmd),
    .strobe_o           (align_strobe),
    .misaligned_load_o  (mis_load),
    .misaligned_store_o (mis_store),
    .rsp_word_i         (rsp_word),
    .rsp_cmd_i          (rsp_cmd),
    .rsp_offset_i       (rsp_offset),
    .rf_data_o          (rf_data_o)
  );

  lsu_core u_core (
    .clk_i                   (clk_i),
    .rstn_i                  (rstn_i),
    .lsu_valid_i             (lsu_valid_i),
    .lsu_ready_o             (lsu_ready_o),
    .cmd_i                   (align_cmd),
    .strobe_i                (align_strobe),
    .misaligned_load_i       (mis_load),
    .misaligned_store_i      (mis_store),
    .req_o                   (bus_req),
    .req_valid_o             (bus_req_valid),
    .req_ready_i             (bus_req_ready),
    .rsp_i                   (bus_rsp),
    .rsp_valid_i             (bus_rsp_valid),
    .rsp_ready_o             (bus_rsp_ready),
    .rsp_word_o              (rsp_word),
    .rsp_cmd_o               (rsp_cmd),
    .rsp_offset_o            (rsp_offset),
    .rf_wb_o                 (rf_wb_o),
    .rf_dest_o               (rf_dest_o),
    .ctrl_misaligned_load_o  (ctrl_misaligned_load_o),
    .ctrl_misaligned_store_o (ctrl_misaligned_store_o),
    .ctrl_bus_error_o        (ctrl_bus_error_o),
    .ctrl_exception_addr_o   (ctrl_exception_addr_o)
  );

  data_ram u_ram (
    .clk_i       (clk_i),
    .rstn_i      (rstn_i),
    .req_i       (bus_req),
    .req_valid_i (bus_req_valid),
    .req_ready_o (bus_req_ready),
    .rsp_o       (bus_rsp),
    .rsp_valid_o (bus_rsp_valid),
    .rsp_ready_i (bus_rsp_ready)
  );

endmodule

/* src/data_ram.sv */
//////////////////////////////////////////////////
// Data RAM
// Word organized memory with byte strobes, one
// held response per request, bus error when the
// address is past the end
//////////////////////////////////////////////////

`timescale 1ns/1ps

module data_ram (
  input  logic                   clk_i,
  input  logic                   rstn_i,
  // Request
  input  mem_bus_pkg::data_req_t req_i,
  input  logic                   req_valid_i,
  output logic                   req_ready_o,
  // Response
  output mem_bus_pkg::data_rsp_t rsp_o,
  output logic                   rsp_valid_o,
  input  logic                   rsp_ready_i
);
  import lsu_pkg::*;
  import mem_bus_pkg::*;

  logic [DATA_WIDTH-1:0]      mem [RAM_WORDS];
  logic [RAM_INDEX_WIDTH-1:0] word_idx;
  logic                       in_range;
  logic                       req_fire, rsp_fire;

  assign word_idx = req_i.addr[RAM_INDEX_WIDTH+1:2];  // Byte address to word
  assign in_range = (req_i.addr < RAM_BYTES);

  // Held response blocks new requests unless it leaves now
  assign rsp_fire    = rsp_valid_o && rsp_ready_i;
  assign req_ready_o = !rsp_valid_o || rsp_fire;
  assign req_fire    = req_valid_i && req_ready_o;

  //////////////////////////////////////////////////
  // Storage
  //////////////////////////////////////////////////
  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      for (int i = 0; i < RAM_WORDS; i++) begin
        mem[i] <= '0;
      end
    end else if (req_fire && req_i.write && in_range) begin
      for (int b = 0; b < 4; b++) begin
        if (req_i.strobe[b]) begin
          mem[word_idx][8*b +: 8] <= req_i.data[8*b +: 8];  // Selected lanes only
        end
      end
    end
  end

  //////////////////////////////////////////////////
  // Response
  //////////////////////////////////////////////////
  always_ff @(posedge clk_i) begin
    if (!rstn_i)       rsp_valid_o <= 1'b0;
    else if (req_fire) rsp_valid_o <= 1'b1;  // Back to back keeps it high
    else if (rsp_fire) rsp_valid_o <= 1'b0;
  end

  always_ff @(posedge clk_i) begin
    if (req_fire) begin
      rsp_o.error <= !in_range;
      rsp_o.data  <= (in_range && !req_i.write) ? mem[word_idx] : '0;
    end
  end

endmodule

/* lsu/lsu_core.sv */
//////////////////////////////////////////////////
// LSU core
// Two entry skid buffer in front of the data bus,
// one request in flight, response capture and
// write-back / exception pulses
//////////////////////////////////////////////////

`timescale 1ns/1ps

module lsu_core (
  input  logic                               clk_i,
  input  logic                               rstn_i,
  // Command side, already aligned
  input  logic                               lsu_valid_i,
  output logic                               lsu_ready_o,
  input  lsu_pkg::lsu_cmd_t                  cmd_i,
  input  logic [3:0]                         strobe_i,
  input  logic                               misaligned_load_i,
  input  logic                               misaligned_store_i,
  // Data memory bus
  output mem_bus_pkg::data_req_t             req_o,
  output logic                               req_valid_o,
  input  logic                               req_ready_i,
  input  mem_bus_pkg::data_rsp_t             rsp_i,
  input  logic                               rsp_valid_i,
  output logic                               rsp_ready_o,
  // Raw response to the alignment block
  output logic [lsu_pkg::DATA_WIDTH-1:0]     rsp_word_o,
  output lsu_pkg::lsu_ctrl_e                 rsp_cmd_o,
  output logic [1:0]                         rsp_offset_o,
  // Register file
  output logic                               rf_wb_o,
  output logic [lsu_pkg::REG_ADDR_WIDTH-1:0] rf_dest_o,
  // Core controller
  output logic                               ctrl_misaligned_load_o,
  output logic                               ctrl_misaligned_store_o,
  output logic                               ctrl_bus_error_o,
  output logic [lsu_pkg::DATA_WIDTH-1:0]     ctrl_exception_addr_o
);
  import lsu_pkg::*;

  // Buffer slot, command plus its strobe
  typedef struct packed {
    lsu_cmd_t   cmd;
    logic [3:0] strobe;
  } skid_entry_t;

  // What the bus is working on
  typedef struct packed {
    lsu_ctrl_e                 cmd;
    logic [DATA_WIDTH-1:0]     addr;
    logic [REG_ADDR_WIDTH-1:0] regdest;
  } issue_rec_t;

  typedef enum logic [1:0] {
    eEMPTY,  // Nothing held
    eBUSY,   // Output buffer on the bus
    eFULL    // Output on the bus, input buffer waiting
  } lsu_fsm_e;

  lsu_fsm_e    state, state_next;
  skid_entry_t ibuf_q, obuf_q, in_entry, sel_entry;
  issue_rec_t  issued_q;
  logic [DATA_WIDTH-1:0] rsp_word_q;
  logic        req_issued_q;  // Output buffer already sent
  logic        load, flow, fill, unload, flush;
  logic        ibuf_en, obuf_en, use_buffered;
  logic        lsu_fire, mis_fire, buf_fire, req_fire, rsp_fire;

  //////////////////////////////////////////////////
  // Handshakes
  //////////////////////////////////////////////////
  assign lsu_fire = lsu_valid_i && lsu_ready_o;
  assign mis_fire = lsu_fire && (misaligned_load_i || misaligned_store_i);
  assign buf_fire = lsu_fire && !mis_fire;  // Only aligned ones enter the buffers
  assign req_fire = req_valid_o && req_ready_i;
  assign rsp_fire = rsp_valid_i && rsp_ready_o;

  //////////////////////////////////////////////////
  // Skid buffer
  //////////////////////////////////////////////////
  assign in_entry  = '{cmd: cmd_i, strobe: strobe_i};
  assign sel_entry = use_buffered ? ibuf_q : in_entry;

  always_ff @(posedge clk_i) begin
    if (ibuf_en) ibuf_q <= in_entry;
    if (obuf_en) obuf_q <= sel_entry;
  end

  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      lsu_ready_o <= 1'b0;
      rsp_ready_o <= 1'b0;
    end else begin
      lsu_ready_o <= (state_next != eFULL);
      rsp_ready_o <= (state_next != eEMPTY);  // Only while something is out
    end
  end

  //////////////////////////////////////////////////
  // Bus request
  //////////////////////////////////////////////////
  assign req_valid_o  = (state != eEMPTY) && !req_issued_q;
  assign req_o.addr   = obuf_q.cmd.addr;
  assign req_o.data   = obuf_q.cmd.data;
  assign req_o.strobe = obuf_q.strobe;
  assign req_o.write  = is_store(obuf_q.cmd.cmd);

  // Keeps the same entry from going out twice
  always_ff @(posedge clk_i) begin
    if (!rstn_i)                req_issued_q <= 1'b0;
    else if (obuf_en || unload) req_issued_q <= 1'b0;  // New entry or drained
    else if (req_fire)          req_issued_q <= 1'b1;
  end

  always_ff @(posedge clk_i) begin
    if (req_fire) begin
      issued_q.cmd     <= obuf_q.cmd.cmd;
      issued_q.addr    <= obuf_q.cmd.addr;
      issued_q.regdest <= obuf_q.cmd.regdest;
    end
    if (rsp_fire) rsp_word_q <= rsp_i.data;
  end

  //////////////////////////////////////////////////
  // Write-back and exceptions
  //////////////////////////////////////////////////
  assign rsp_word_o   = rsp_word_q;
  assign rsp_cmd_o    = issued_q.cmd;
  assign rsp_offset_o = issued_q.addr[1:0];
  assign rf_dest_o    = issued_q.regdest;  // Stable until the next request fires

  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      rf_wb_o                 <= 1'b0;
      ctrl_bus_error_o        <= 1'b0;
      ctrl_misaligned_load_o  <= 1'b0;
      ctrl_misaligned_store_o <= 1'b0;
      ctrl_exception_addr_o   <= '0;
    end else begin
      rf_wb_o                 <= rsp_fire && !rsp_i.error && !is_store(issued_q.cmd);
      ctrl_bus_error_o        <= rsp_fire && rsp_i.error;
      ctrl_misaligned_load_o  <= lsu_fire && misaligned_load_i;
      ctrl_misaligned_store_o <= lsu_fire && misaligned_store_i;
      if (rsp_fire && rsp_i.error) begin
        ctrl_exception_addr_o <= issued_q.addr;  // Older access wins
      end else if (mis_fire) begin
        ctrl_exception_addr_o <= cmd_i.addr;
      end
    end
  end

  //////////////////////////////////////////////////
  // FSM
  //////////////////////////////////////////////////
  always_comb begin
    load   = (state == eEMPTY) &&  buf_fire;
    flow   = (state == eBUSY)  &&  buf_fire &&  rsp_fire;
    fill   = (state == eBUSY)  &&  buf_fire && !rsp_fire;
    unload = (state == eBUSY)  && !buf_fire &&  rsp_fire;
    flush  = (state == eFULL)  && !buf_fire &&  rsp_fire;
  end

  always_comb begin
    obuf_en      = load || flow || flush;
    ibuf_en      = fill;
    use_buffered = flush;  // Drain the skid slot first
  end

  always_comb begin
    state_next = state;
    if (load || flow || flush) state_next = eBUSY;
    if (fill)                  state_next = eFULL;
    if (unload)                state_next = eEMPTY;
  end

  always_ff @(posedge clk_i) begin
    if (!rstn_i) state <= eEMPTY;
    else         state <= state_next;
  end

endmodule

/* lsu/lsu_align.sv */
//////////////////////////////////////////////////
// LSU alignment
// Request side: alignment check, byte lane
// steering and strobes. Response side: byte or
// half-word pick and sign/zero extension
//////////////////////////////////////////////////

`timescale 1ns/1ps

module lsu_align (
  // Request side
  input  lsu_pkg::lsu_cmd_t              cmd_i,
  output lsu_pkg::lsu_cmd_t              cmd_o,
  output logic [3:0]                     strobe_o,
  output logic                           misaligned_load_o,
  output logic                           misaligned_store_o,
  // Response side
  input  logic [lsu_pkg::DATA_WIDTH-1:0] rsp_word_i,
  input  lsu_pkg::lsu_ctrl_e             rsp_cmd_i,
  input  logic [1:0]                     rsp_offset_i,
  output logic [lsu_pkg::DATA_WIDTH-1:0] rf_data_o
);
  import lsu_pkg::*;

  logic [1:0]            req_offset;
  logic                  req_misaligned;
  logic [DATA_WIDTH-1:0] rsp_shifted;

  //////////////////////////////////////////////////
  // Request side
  //////////////////////////////////////////////////
  always_comb begin
    req_offset = cmd_i.addr[1:0];

    // Word on 4 bytes, half on 2, bytes anywhere
    req_misaligned = (is_word(cmd_i.cmd) && (req_offset != 2'b00))
                  || (is_half(cmd_i.cmd) && req_offset[0]);
    misaligned_load_o  = req_misaligned && !is_store(cmd_i.cmd);
    misaligned_store_o = req_misaligned &&  is_store(cmd_i.cmd);

    // Store data moves up into its lanes
    cmd_o      = cmd_i;
    cmd_o.data = cmd_i.data << {req_offset, 3'b000};

    case (cmd_i.cmd)
      LSU_STORE_BYTE:      strobe_o = 4'b0001 << req_offset;
      LSU_STORE_HALF_WORD: strobe_o = 4'b0011 << req_offset;
      default:             strobe_o = 4'b1111;  // Word store and all loads
    endcase
  end

  //////////////////////////////////////////////////
  // Response side
  //////////////////////////////////////////////////
  always_comb begin
    // Addressed lane down to bit 0
    rsp_shifted = rsp_word_i >> {rsp_offset_i, 3'b000};

    case (rsp_cmd_i)
      LSU_LOAD_BYTE: begin
        rf_data_o = {{(DATA_WIDTH-8){rsp_shifted[7]}}, rsp_shifted[7:0]};
      end
      LSU_LOAD_BYTE_U: begin
        rf_data_o = {{(DATA_WIDTH-8){1'b0}}, rsp_shifted[7:0]};
      end
      LSU_LOAD_HALF_WORD: begin
        rf_data_o = {{(DATA_WIDTH-16){rsp_shifted[15]}}, rsp_shifted[15:0]};
      end
      LSU_LOAD_HALF_WORD_U: begin
        rf_data_o = {{(DATA_WIDTH-16){1'b0}}, rsp_shifted[15:0]};
      end
      default: rf_data_o = rsp_word_i;  // LW, stores never write back
    endcase
  end

endmodule

/* common/mem_bus_pkg.sv */
//////////////////////////////////////////////////
// Data memory bus package
// Request/response words of the LSU to RAM bus
// and the size of the data RAM
//////////////////////////////////////////////////

package mem_bus_pkg;
  import lsu_pkg::*;

  // RAM geometry
  localparam int RAM_WORDS       = 256;
  localparam int RAM_INDEX_WIDTH = $clog2(RAM_WORDS);
  localparam logic [DATA_WIDTH-1:0] RAM_BYTES = DATA_WIDTH'(4 * RAM_WORDS);  // First bad addr

  // Request, 69 bits
  typedef struct packed {
    logic [DATA_WIDTH-1:0] addr;
    logic [DATA_WIDTH-1:0] data;    // Already lane aligned
    logic [3:0]            strobe;  // One bit per byte lane
    logic                  write;
  } data_req_t;

  // Response, 33 bits
  typedef struct packed {
    logic [DATA_WIDTH-1:0] data;   // Raw word, zero on store or error
    logic                  error;  // Address out of range
  } data_rsp_t;

endpackage

/* common/lsu_pkg.sv */
//////////////////////////////////////////////////
// LSU package
// Widths, load/store opcodes and the command
// word handed from the decoder to the LSU
//////////////////////////////////////////////////

package lsu_pkg;

  //////////////////////////////////////////////////
  // Widths
  //////////////////////////////////////////////////
  localparam int DATA_WIDTH     = 32;  // XLEN, also address width
  localparam int REG_ADDR_WIDTH = 5;   // x0..x31

  //////////////////////////////////////////////////
  // Opcodes
  //////////////////////////////////////////////////
  typedef enum logic [2:0] {
    LSU_LOAD_BYTE        = 3'd0,  // LB
    LSU_LOAD_HALF_WORD   = 3'd1,  // LH
    LSU_LOAD_WORD        = 3'd2,  // LW
    LSU_LOAD_BYTE_U      = 3'd3,  // LBU
    LSU_LOAD_HALF_WORD_U = 3'd4,  // LHU
    LSU_STORE_BYTE       = 3'd5,  // SB
    LSU_STORE_HALF_WORD  = 3'd6,  // SH
    LSU_STORE_WORD       = 3'd7   // SW
  } lsu_ctrl_e;

  // One command, 72 bits
  typedef struct packed {
    lsu_ctrl_e                 cmd;
    logic [DATA_WIDTH-1:0]     addr;     // Effective address
    logic [DATA_WIDTH-1:0]     data;     // Store data
    logic [REG_ADDR_WIDTH-1:0] regdest;  // Load target register
  } lsu_cmd_t;

  // Store opcodes write memory, all others read
  function automatic logic is_store(lsu_ctrl_e op);
    return op inside {LSU_STORE_BYTE, LSU_STORE_HALF_WORD, LSU_STORE_WORD};
  endfunction

  // Word sized access, must sit on a 4-byte boundary
  function automatic logic is_word(lsu_ctrl_e op);
    return op inside {LSU_LOAD_WORD, LSU_STORE_WORD};
  endfunction

  // Half-word access, 2-byte boundary
  function automatic logic is_half(lsu_ctrl_e op);
    return op inside {LSU_LOAD_HALF_WORD, LSU_LOAD_HALF_WORD_U, LSU_STORE_HALF_WORD};
  endfunction

endpackage
